// ==== design/mem_stage_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Shared types and constants for the memory-access stage.
////////////////////////////////////////////////////////////

package mem_stage_pkg;

   // Datapath geometry.
   localparam int DATA_WIDTH = 32;   // Bits per data word.
   localparam int LANE_COUNT = 4;    // Byte lanes per word.

   ////////////////////////////////////////////////////////////
   // MIPS primary opcodes handled by the stage.
   ////////////////////////////////////////////////////////////

   typedef enum logic [5:0] {
      OP_LB  = 6'h20,   // Load signed byte.
      OP_LH  = 6'h21,   // Load signed halfword.
      OP_LW  = 6'h23,   // Load word.
      OP_LBU = 6'h24,   // Load unsigned byte.
      OP_LHU = 6'h25,   // Load unsigned halfword.
      OP_SB  = 6'h28,   // Store byte.
      OP_SH  = 6'h29,   // Store halfword.
      OP_SW  = 6'h2B    // Store word.
   } mem_opcode_t;

   // Access size select.
   // Encoding matches the byte-lane enable select.
   typedef enum logic [1:0] {
      SIZE_NONE = 2'd0,   // No access.
      SIZE_BYTE = 2'd1,   // One lane.
      SIZE_HALF = 2'd2,   // Two lanes.
      SIZE_WORD = 2'd3    // All lanes.
   } access_size_t;

endpackage

`default_nettype wire

// ==== design/mem_stage_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////
// Decoded request from decoder to data memory.
////////////////////////////////////////////////////////////

interface mem_access_if #(
   parameter int MEM_ADDR_WIDTH = 10
);
   import mem_stage_pkg::*;

   logic                      access_load;    // One-cycle load qualifier.
   logic                      access_store;   // One-cycle store qualifier.
   access_size_t              access_size;
   logic                      access_sign;    // Sign-extend on load.
   logic [1:0]                lane_offset;    // Byte within the word.
   logic [MEM_ADDR_WIDTH-3:0] word_index;
   logic [DATA_WIDTH-1:0]     store_data;
   logic                      access_fault;   // Misaligned known opcode.

   modport decoder_mp (
      output access_load, access_store, access_size, access_sign,
      output lane_offset, word_index, store_data, access_fault
   );

   modport memory_mp (
      input access_load, access_store, access_size, access_sign,
      input lane_offset, word_index, store_data, access_fault
   );
endinterface

////////////////////////////////////////////////////////////
// Registered read word from data memory to result aligner.
////////////////////////////////////////////////////////////

interface load_return_if;
   import mem_stage_pkg::*;

   logic                  return_valid;
   logic [DATA_WIDTH-1:0] return_word;    // Whole addressed word.
   access_size_t          return_size;
   logic                  return_sign;
   logic [1:0]            return_offset;
   logic                  return_fault;   // Delayed alignment fault.

   modport memory_mp (
      output return_valid, return_word, return_size,
      output return_sign, return_offset, return_fault
   );

   modport align_mp (
      input return_valid, return_word, return_size,
      input return_sign, return_offset, return_fault
   );
endinterface

`default_nettype wire

// ==== design/byte_lane_enable.sv ====
`timescale 1ns/100ps
`default_nettype none

// Byte-lane write enables for a store.
module byte_lane_enable (
   input  wire logic                                i_write,
   input  wire mem_stage_pkg::access_size_t         i_size,
   input  wire logic [1:0]                          i_lane_offset,
   output logic [mem_stage_pkg::LANE_COUNT-1:0]     o_lane_enable
);
   import mem_stage_pkg::*;

   localparam int HALF_LANES = LANE_COUNT / 2;

   always_comb begin
      o_lane_enable = '0;   // Reads and idle cycles.
      if (i_write) begin
         case (i_size)
            SIZE_WORD: begin
               o_lane_enable = '1;   // Full word.
            end
            SIZE_HALF: begin
               // Offset bit 1 picks the upper pair.
               if (i_lane_offset[1]) begin
                  o_lane_enable = {{HALF_LANES{1'b1}}, {HALF_LANES{1'b0}}};
               end
               else begin
                  o_lane_enable = {{HALF_LANES{1'b0}}, {HALF_LANES{1'b1}}};
               end
            end
            SIZE_BYTE: begin
               o_lane_enable = LANE_COUNT'(1) << i_lane_offset;   // One lane.
            end
            default: begin
               o_lane_enable = '0;
            end
         endcase
      end

      assert (i_write || o_lane_enable == '0)
         else $error("Lane enable raised without a write.");
   end

endmodule

`default_nettype wire

// ==== design/mem_op_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// Opcode and address decode. Purely combinational.
module mem_op_decoder #(
   parameter int MEM_ADDR_WIDTH = 10
) (
   input  wire logic                                i_mem_valid,
   input  wire mem_stage_pkg::mem_opcode_t          i_mem_opcode,
   input  wire logic [MEM_ADDR_WIDTH-1:0]           i_mem_address,
   input  wire logic [mem_stage_pkg::DATA_WIDTH-1:0] i_store_data,
   mem_access_if.decoder_mp                         access
);
   import mem_stage_pkg::*;

   logic         is_load;      // Opcode is a load.
   logic         is_store;     // Opcode is a store.
   access_size_t size;
   logic         sign;
   logic         misaligned;
   logic         do_load;
   logic         do_store;
   logic         do_fault;

   ////////////////////////////////////////////////////////////
   // Opcode map and alignment check.
   ////////////////////////////////////////////////////////////

   always_comb begin
      is_load  = 1'b0;
      is_store = 1'b0;
      size     = SIZE_NONE;   // Unknown opcodes stay here.
      sign     = 1'b0;
      case (i_mem_opcode)
         OP_LB:  begin is_load = 1'b1; size = SIZE_BYTE; sign = 1'b1; end
         OP_LH:  begin is_load = 1'b1; size = SIZE_HALF; sign = 1'b1; end
         OP_LW:  begin is_load = 1'b1; size = SIZE_WORD; end
         OP_LBU: begin is_load = 1'b1; size = SIZE_BYTE; end
         OP_LHU: begin is_load = 1'b1; size = SIZE_HALF; end
         OP_SB:  begin is_store = 1'b1; size = SIZE_BYTE; end
         OP_SH:  begin is_store = 1'b1; size = SIZE_HALF; end
         OP_SW:  begin is_store = 1'b1; size = SIZE_WORD; end
         default: ;
      endcase

      // Natural alignment only.
      case (size)
         SIZE_HALF: misaligned = i_mem_address[0];
         SIZE_WORD: misaligned = |i_mem_address[1:0];
         default:   misaligned = 1'b0;   // Bytes always fit.
      endcase

      do_load  = i_mem_valid & is_load & ~misaligned;
      do_store = i_mem_valid & is_store & ~misaligned;
      do_fault = i_mem_valid & (is_load | is_store) & misaligned;

      assert (!(do_load && do_store))
         else $error("Decoder issued load and store together.");
   end

   ////////////////////////////////////////////////////////////
   // Drive the request bundle.
   ////////////////////////////////////////////////////////////

   assign access.access_load  = do_load;
   assign access.access_store = do_store;
   assign access.access_fault = do_fault;        // Access is held off.
   assign access.access_size  = size;
   assign access.access_sign  = sign;
   assign access.lane_offset  = i_mem_address[1:0];
   assign access.word_index   = i_mem_address[MEM_ADDR_WIDTH-1:2];
   assign access.store_data   = i_store_data;

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

// Word-organized data memory with masked byte-lane writes.
module data_memory #(
   parameter int MEM_ADDR_WIDTH = 10
) (
   input  wire logic        i_clock,
   input  wire logic        i_reset,
   mem_access_if.memory_mp  access,
   load_return_if.memory_mp ret
);
   import mem_stage_pkg::*;

   localparam int WORD_COUNT = 2 ** (MEM_ADDR_WIDTH - 2);
   localparam int LANE_WIDTH = DATA_WIDTH / LANE_COUNT;   // 8 bits.

   logic [DATA_WIDTH-1:0] mem [WORD_COUNT];   // One entry per word.
   logic [LANE_COUNT-1:0] lane_enable;
   logic [DATA_WIDTH-1:0] write_word;        // Store data after replication.

   ////////////////////////////////////////////////////////////
   // Write path.
   ////////////////////////////////////////////////////////////

   byte_lane_enable byte_lane_enable_inst (
      .i_write       (access.access_store),
      .i_size        (access.access_size),
      .i_lane_offset (access.lane_offset),
      .o_lane_enable (lane_enable)
   );

   // Copy the low byte or halfword into every lane.
   always_comb begin
      case (access.access_size)
         SIZE_BYTE: write_word = {LANE_COUNT{access.store_data[LANE_WIDTH-1:0]}};
         SIZE_HALF: write_word = {(LANE_COUNT / 2){access.store_data[2*LANE_WIDTH-1:0]}};
         default:   write_word = access.store_data;
      endcase
   end

   always_ff @(posedge i_clock) begin
      for (int lane = 0; lane < LANE_COUNT; lane++) begin
         if (lane_enable[lane]) begin
            mem[access.word_index][lane*LANE_WIDTH +: LANE_WIDTH] <=
               write_word[lane*LANE_WIDTH +: LANE_WIDTH];   // Enabled lanes only.
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Read path with one register stage.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         ret.return_valid <= 1'b0;
         ret.return_fault <= 1'b0;
      end
      else begin
         ret.return_valid <= access.access_load;
         ret.return_fault <= access.access_fault;   // Keeps pace with loads.
      end
   end

   // Payload is captured on loads only.
   always_ff @(posedge i_clock) begin
      if (access.access_load) begin
         ret.return_word   <= mem[access.word_index];
         ret.return_size   <= access.access_size;
         ret.return_sign   <= access.access_sign;
         ret.return_offset <= access.lane_offset;
      end
   end

   // Misaligned stores must never reach the array.
   assert property (@(posedge i_clock) disable iff (i_reset)
      access.access_fault |-> lane_enable == '0)
      else $error("Lane write during a misaligned access.");

endmodule

`default_nettype wire

// ==== design/load_result_align.sv ====
`timescale 1ns/100ps
`default_nettype none

// Load alignment and extension with registered outputs.
module load_result_align (
   input  wire logic                                 i_clock,
   input  wire logic                                 i_reset,
   load_return_if.align_mp                           ret,
   output logic                                      o_load_valid,
   output logic [mem_stage_pkg::DATA_WIDTH-1:0]      o_load_data,
   output logic                                      o_align_error
);
   import mem_stage_pkg::*;

   localparam int LANE_WIDTH = DATA_WIDTH / LANE_COUNT;
   localparam int HALF_WIDTH = 2 * LANE_WIDTH;

   logic [DATA_WIDTH-1:0] shifted;   // Addressed lane moved to bit 0.
   logic [DATA_WIDTH-1:0] result;
   logic                  byte_fill;
   logic                  half_fill;

   ////////////////////////////////////////////////////////////
   // Lane select and extension.
   ////////////////////////////////////////////////////////////

   always_comb begin
      shifted   = ret.return_word >> (ret.return_offset * LANE_WIDTH);
      byte_fill = ret.return_sign & shifted[LANE_WIDTH-1];   // Zero for LBU.
      half_fill = ret.return_sign & shifted[HALF_WIDTH-1];   // Zero for LHU.
      case (ret.return_size)
         SIZE_BYTE: begin
            result = {{(DATA_WIDTH - LANE_WIDTH){byte_fill}}, shifted[LANE_WIDTH-1:0]};
         end
         SIZE_HALF: begin
            result = {{(DATA_WIDTH - HALF_WIDTH){half_fill}}, shifted[HALF_WIDTH-1:0]};
         end
         default: begin
            result = ret.return_word;   // Whole word without a shift.
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Output registers.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_load_valid  <= 1'b0;
         o_align_error <= 1'b0;
      end
      else begin
         o_load_valid  <= ret.return_valid;
         o_align_error <= ret.return_fault;
      end
   end

   always_ff @(posedge i_clock) begin
      if (ret.return_valid) begin
         o_load_data <= result;   // Held between loads.
      end
   end

   // A request gives a load result or a fault but never both.
   assert property (@(posedge i_clock) disable iff (i_reset)
      !(o_load_valid && o_align_error))
      else $error("Load valid and align error raised together.");

endmodule

`default_nettype wire

// ==== design/mem_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////
// Memory-access stage top level.
// Decode, data memory and result align in a two-cycle pipe.
////////////////////////////////////////////////////////////

module mem_stage_top #(
   parameter int MEM_ADDR_WIDTH = 10   // Byte address width.
) (
   input  wire logic                                 i_clock,
   input  wire logic                                 i_reset,
   input  wire logic                                 i_mem_valid,     // Request strobe.
   input  wire mem_stage_pkg::mem_opcode_t           i_mem_opcode,
   input  wire logic [MEM_ADDR_WIDTH-1:0]            i_mem_address,
   input  wire logic [mem_stage_pkg::DATA_WIDTH-1:0] i_store_data,
   output logic                                      o_load_valid,    // Cycle N+2.
   output logic [mem_stage_pkg::DATA_WIDTH-1:0]      o_load_data,
   output logic                                      o_align_error    // Cycle N+2.
);

   // Decoder to memory.
   mem_access_if #(
      .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
   ) access_bus ();

   // Memory to aligner.
   load_return_if return_bus ();

   ////////////////////////////////////////////////////////////
   // Stage instances.
   ////////////////////////////////////////////////////////////

   mem_op_decoder #(
      .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
   ) mem_op_decoder_inst (
      .i_mem_valid   (i_mem_valid),
      .i_mem_opcode  (i_mem_opcode),
      .i_mem_address (i_mem_address),
      .i_store_data  (i_store_data),
      .access        (access_bus.decoder_mp)
   );

   data_memory #(
      .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
   ) data_memory_inst (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .access  (access_bus.memory_mp),
      .ret     (return_bus.memory_mp)
   );

   load_result_align load_result_align_inst (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .ret           (return_bus.align_mp),
      .o_load_valid  (o_load_valid),
      .o_load_data   (o_load_data),
      .o_align_error (o_align_error)
   );

endmodule

`default_nettype wire

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
   import mem_stage_pkg::*;

   localparam int ADDR_WIDTH     = 10;   // DUT default.
   localparam int TIMEOUT_CYCLES = 10;
   localparam int LOAD_LATENCY   = 2;    // Strobe to result.
   localparam int STREAM_LENGTH  = 64;
   localparam logic [ADDR_WIDTH-1:0] STREAM_BASE = 10'h200;   // 16-word window.

   logic                  i_clock;
   logic                  i_reset;
   logic                  i_mem_valid;
   mem_opcode_t           i_mem_opcode;
   logic [ADDR_WIDTH-1:0] i_mem_address;
   logic [DATA_WIDTH-1:0] i_store_data;
   logic                  o_load_valid;
   logic [DATA_WIDTH-1:0] o_load_data;
   logic                  o_align_error;

   logic [7:0]  model [2**ADDR_WIDTH];   // Byte-wide reference memory.
   logic [31:0] rng_state;
   string       test_name;
   int          test_start_errors;
   int          check_count;
   int          error_count;

   mem_stage_top mem_stage_top_inst (.*);

   always #10 i_clock = ~i_clock;   // 20 ns period.

   ////////////////////////////////////////////////////////////
   // Reference model.
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_random();   // xorshift32.
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic is_load(input mem_opcode_t opcode);
      return opcode inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
   endfunction

   function automatic logic misaligned(input mem_opcode_t opcode,
         input logic [ADDR_WIDTH-1:0] address);
      case (opcode)
         OP_LH, OP_LHU, OP_SH: return address[0];
         OP_LW, OP_SW:         return |address[1:0];
         default:              return 1'b0;   // Bytes and unknown opcodes.
      endcase
   endfunction

   // Little-endian lanes. Offset 0 is bits 7:0.
   function automatic logic [DATA_WIDTH-1:0] expected_load(input mem_opcode_t opcode,
         input logic [ADDR_WIDTH-1:0] address);
      logic [7:0]  low_byte;
      logic [15:0] half;
      low_byte = model[address];
      half     = {model[address + 10'd1], model[address]};
      case (opcode)
         OP_LB:   return {{24{low_byte[7]}}, low_byte};
         OP_LBU:  return {24'h000000, low_byte};
         OP_LH:   return {{16{half[15]}}, half};
         OP_LHU:  return {16'h0000, half};
         default: return {model[address + 10'd3], model[address + 10'd2], half};
      endcase
   endfunction

   function automatic void apply_store(input mem_opcode_t opcode,
         input logic [ADDR_WIDTH-1:0] address, input logic [DATA_WIDTH-1:0] data);
      int bytes;
      case (opcode)
         OP_SB:   bytes = 1;
         OP_SH:   bytes = 2;
         OP_SW:   bytes = 4;
         default: bytes = 0;   // Loads and unknown opcodes.
      endcase
      for (int i = 0; i < bytes; i++) begin
         model[address + ADDR_WIDTH'(i)] = data[8*i +: 8];
      end
   endfunction

   ////////////////////////////////////////////////////////////
   // Drive, compare and report.
   ////////////////////////////////////////////////////////////

   task automatic drive_request(input logic valid, input mem_opcode_t opcode,
         input logic [ADDR_WIDTH-1:0] address, input logic [DATA_WIDTH-1:0] data);
      i_mem_valid   = valid;
      i_mem_opcode  = opcode;
      i_mem_address = address;
      i_store_data  = data;
   endtask

   task automatic next_cycle();
      @(posedge i_clock);
      #2;   // Inputs change well after the edge.
   endtask

   task automatic compare_load_data(input logic [DATA_WIDTH-1:0] expected,
         input logic [DATA_WIDTH-1:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
      end
   endtask

   task automatic compare_flag(input logic expected, input logic actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Fail %s: expected %b, actual %b", test_name, expected, actual);
      end
   endtask

   task automatic start_test(input string name);
      test_name         = name;
      test_start_errors = error_count;
   endtask

   task automatic finish_test();
      $display("Test %s done with %0d errors", test_name, error_count - test_start_errors);
   endtask

   // One request followed by its response or the lack of one.
   task automatic run_request(input mem_opcode_t opcode,
         input logic [ADDR_WIDTH-1:0] address, input logic [DATA_WIDTH-1:0] data);
      logic                  fault;
      logic [DATA_WIDTH-1:0] expected;
      int                    cycles;
      fault    = misaligned(opcode, address);
      expected = expected_load(opcode, address);
      if (!fault) apply_store(opcode, address, data);
      drive_request(1'b1, opcode, address, data);
      next_cycle();
      drive_request(1'b0, OP_LW, '0, '0);
      if (is_load(opcode) || fault) begin
         cycles = 1;
         while (cycles <= TIMEOUT_CYCLES && !o_load_valid && !o_align_error) begin
            next_cycle();
            cycles++;
         end
         if (cycles > TIMEOUT_CYCLES) begin
            error_count++;
            $display("%s: no response to opcode %h at address %h within %0d cycles",
               test_name, opcode, address, TIMEOUT_CYCLES);
         end
         else begin
            if (cycles != LOAD_LATENCY) begin
               error_count++;
               $display("%s: response came %0d cycles after the strobe instead of %0d",
                  test_name, cycles, LOAD_LATENCY);
            end
            compare_flag(fault, o_align_error);
            compare_flag(!fault, o_load_valid);
            if (!fault) compare_load_data(expected, o_load_data);
         end
      end
      else begin
         repeat (LOAD_LATENCY + 1) begin   // Stores stay silent.
            next_cycle();
            compare_flag(1'b0, o_load_valid);
            compare_flag(1'b0, o_align_error);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests.
   ////////////////////////////////////////////////////////////

   task automatic word_store_load();
      start_test("word_store_load");
      for (int i = 0; i < 4; i++) run_request(OP_SW, ADDR_WIDTH'(i * 260), next_random());
      for (int i = 0; i < 4; i++) run_request(OP_LW, ADDR_WIDTH'(i * 260), '0);
      finish_test();
   endtask

   task automatic byte_lanes();
      start_test("byte_lanes");
      for (int i = 0; i < 4; i++) begin
         run_request(OP_SB, 10'h040 + ADDR_WIDTH'(i), 32'h817EC35A >> (8 * i));   // Junk above.
      end
      run_request(OP_LW, 10'h040, '0);    // Merged word.
      run_request(OP_LB, 10'h041, '0);    // 0xC3 is negative.
      run_request(OP_LBU, 10'h041, '0);
      run_request(OP_LB, 10'h042, '0);    // 0x7E is positive.
      run_request(OP_LB, 10'h043, '0);
      run_request(OP_LBU, 10'h043, '0);
      finish_test();
   endtask

   task automatic halfwords();
      start_test("halfwords");
      run_request(OP_SW, 10'h080, 32'h01234567);
      run_request(OP_SH, 10'h080, 32'hFFFF8ABC);
      run_request(OP_LH, 10'h080, '0);
      run_request(OP_LHU, 10'h080, '0);
      run_request(OP_LW, 10'h080, '0);    // Upper half still 0x0123.
      run_request(OP_SH, 10'h082, 32'h12349F01);
      run_request(OP_LH, 10'h082, '0);
      run_request(OP_LHU, 10'h082, '0);
      run_request(OP_LW, 10'h080, '0);
      finish_test();
   endtask

   task automatic misalignment();
      start_test("misalignment");
      run_request(OP_SW, 10'h0C0, next_random());
      run_request(OP_LH, 10'h0C1, '0);
      run_request(OP_LW, 10'h0C2, '0);
      run_request(OP_SW, 10'h0C2, 32'hFFFFFFFF);   // Must not land.
      run_request(OP_SH, 10'h0C3, 32'h0000FFFF);
      run_request(OP_LW, 10'h0C0, '0);
      finish_test();
   endtask

   task automatic unknown_opcodes();
      start_test("unknown_opcodes");
      run_request(OP_SW, 10'h100, next_random());
      run_request(mem_opcode_t'(6'h2A), 10'h100, 32'hDEADBEEF);
      run_request(mem_opcode_t'(6'h3F), 10'h100, 32'h0BADF00D);
      run_request(OP_LW, 10'h100, '0);
      finish_test();
   endtask

   // New request every cycle with results checked two strobes later.
   task automatic back_to_back_stream();
      mem_opcode_t           opcodes [8];
      logic                  expect_valid_q [$];
      logic [DATA_WIDTH-1:0] expect_data_q [$];
      logic                  expect_valid;
      logic [DATA_WIDTH-1:0] expect_data;
      logic [31:0]           pick;
      logic [DATA_WIDTH-1:0] data;
      mem_opcode_t           opcode;
      logic [1:0]            offset;
      logic [ADDR_WIDTH-1:0] address;
      start_test("back_to_back_stream");
      opcodes = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
      for (int w = 0; w < 16; w++) begin
         run_request(OP_SW, STREAM_BASE + ADDR_WIDTH'(4 * w), next_random());   // Known fill.
      end
      for (int i = 0; i < STREAM_LENGTH + LOAD_LATENCY; i++) begin
         if (i >= LOAD_LATENCY) begin
            expect_valid = expect_valid_q.pop_front();
            expect_data  = expect_data_q.pop_front();
            compare_flag(expect_valid, o_load_valid);
            compare_flag(1'b0, o_align_error);
            if (expect_valid) compare_load_data(expect_data, o_load_data);
         end
         if (i < STREAM_LENGTH) begin
            pick   = next_random();
            data   = next_random();
            opcode = opcodes[pick[2:0]];
            case (opcode)
               OP_LB, OP_LBU, OP_SB: offset = pick[4:3];
               OP_LH, OP_LHU, OP_SH: offset = {pick[3], 1'b0};
               default:              offset = 2'b00;
            endcase
            address = STREAM_BASE + {4'h0, pick[8:5], offset};
            expect_valid_q.push_back(is_load(opcode));
            expect_data_q.push_back(expected_load(opcode, address));
            apply_store(opcode, address, data);
            drive_request(1'b1, opcode, address, data);
         end
         else begin
            drive_request(1'b0, OP_LW, '0, '0);   // Drain.
         end
         next_cycle();
      end
      finish_test();
   endtask

   initial begin
      i_clock = 1'b0;
      i_reset = 1'b1;
      drive_request(1'b0, OP_LW, '0, '0);
      rng_state   = 32'd89846;
      check_count = 0;
      error_count = 0;
      repeat (3) @(posedge i_clock);   // Three reset cycles.
      #2;
      i_reset = 1'b0;
      next_cycle();
      word_store_load();
      byte_lanes();
      halfwords();
      misalignment();
      unknown_opcodes();
      back_to_back_stream();
      $display("Summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end
      else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
design/mem_stage_pkg.sv
design/mem_stage_ifs.sv
design/byte_lane_enable.sv
design/mem_op_decoder.sv
design/data_memory.sv
design/load_result_align.sv
design/mem_stage_top.sv
test/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_stage
FILELIST  = list.f
LOG       = sim.log
PASS_TEXT = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
